// ==== ahb_pkg.sv ====
/*
 * AHB-side types shared by the bridge RTL and its testbench.
 * Covers bus widths, the transfer type encoding and the captured command.
 */

package ahb_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  // Byte address, same width on AHB and APB
  typedef logic [31:0] haddr_t;

  // Read and write data words
  typedef logic [31:0] hdata_t;

  // ----------------------------------------
  // Transfer type, AHB encoding
  // ----------------------------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Address phase fields kept for the data phase
  typedef struct packed {
    haddr_t addr;
    logic   write;
  } ahb_cmd_t;

endpackage : ahb_pkg

// ==== apb_pkg.sv ====
/*
 * APB-side types, slave count and address map of the bridge.
 * Word and address types come from the AHB package.
 */

package apb_pkg;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Four slaves, one 4 KB window each
  localparam int NUM_SLAVES     = 4;
  localparam int SLAVE_WIN_BITS = 12;

  // Slave i starts at SLAVE_BASE + i * 4 KB
  localparam ahb_pkg::haddr_t SLAVE_BASE = 32'h0000_0000;

  // ----------------------------------------
  // Slave select and read data
  // ----------------------------------------
  // One bit per slave, at most one set
  typedef logic [NUM_SLAVES-1:0] psel_vec_t;

  // Read data from all slaves, index = slave number
  typedef ahb_pkg::hdata_t [NUM_SLAVES-1:0] prdata_arr_t;

  // ----------------------------------------
  // APB master states
  // ----------------------------------------
  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_e;

endpackage : apb_pkg

// ==== ahb_slave_port.sv ====
/*
 * AHB slave side of the bridge. Qualifies transfers, holds hready low
 * while the APB side works and returns the read data on completion.
 */

`timescale 1ns/100ps

module ahb_slave_port
  import ahb_pkg::*;
(
  input  logic     hclk30,
  input  logic     hreset_n30,
  input  logic     hsel,
  input  htrans_e  htrans,
  input  haddr_t   haddr,
  input  logic     hwrite,
  input  logic     done,
  input  hdata_t   rdata,
  output logic     hready,
  output hdata_t   hrdata,
  output logic     accept,
  output ahb_cmd_t cmd,
  output logic     data_phase
);

  // ----------------------------------------
  // Transfer qualification
  // ----------------------------------------
  // Address phase whenever no data phase is pending
  assign hready = ~data_phase;

  // Only NONSEQ and SEQ start a transfer; IDLE and BUSY are ignored
  assign accept = hready && hsel &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // ----------------------------------------
  // Phase tracking and read return
  // ----------------------------------------
  always_ff @(posedge hclk30 or negedge hreset_n30) begin
    if (!hreset_n30) begin
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else if (accept) begin
      data_phase <= 1'b1;
    end else if (done) begin
      data_phase <= 1'b0;
      hrdata     <= rdata;
    end
  end

  // Command fields held for the APB side
  always_ff @(posedge hclk30) begin
    if (accept) begin
      cmd.addr  <= haddr;
      cmd.write <= hwrite;
    end
  end

endmodule : ahb_slave_port

// ==== apb_slave_decoder.sv ====
/*
 * Registered address decode into a one-hot APB slave select.
 * Updated on each accepted AHB transfer, held in between.
 */

`timescale 1ns/100ps

module apb_slave_decoder
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  logic      hclk30,
  input  logic      hreset_n30,
  input  haddr_t    haddr,
  input  logic      accept,
  output psel_vec_t slave_sel
);

  psel_vec_t match;

  // Window compare on the address bits above the window size
  always_comb begin
    haddr_t win_base;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      win_base = SLAVE_BASE + (haddr_t'(i) << SLAVE_WIN_BITS);
      match[i] = ((haddr >> SLAVE_WIN_BITS) == (win_base >> SLAVE_WIN_BITS));
    end
  end

  // No match leaves all bits clear
  always_ff @(posedge hclk30 or negedge hreset_n30) begin
    if (!hreset_n30) begin
      slave_sel <= '0;
    end else if (accept) begin
      slave_sel <= match;
    end
  end

endmodule : apb_slave_decoder

// ==== apb_master_fsm.sv ====
/*
 * APB master of the bridge. Runs IDLE, SETUP and ACCESS for each AHB
 * transfer and muxes pready and prdata back from the selected slave.
 */

`timescale 1ns/100ps

module apb_master_fsm
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  logic        hclk30,
  input  logic        hreset_n30,
  input  logic        data_phase,
  input  ahb_cmd_t    cmd,
  input  psel_vec_t   slave_sel,
  input  hdata_t      hwdata,
  input  psel_vec_t   pready,
  input  prdata_arr_t prdata,
  output psel_vec_t   psel,
  output logic        penable,
  output haddr_t      paddr,
  output logic        pwrite,
  output hdata_t      pwdata,
  output logic        done,
  output hdata_t      rdata
);

  apb_state_e state;
  logic       pready_mux;
  logic       sel_empty;
  hdata_t     prdata_mux;

  // Write data is valid for the whole AHB data phase
  assign pwdata = hwdata;

  // ----------------------------------------
  // Return path muxing
  // ----------------------------------------
  always_comb begin
    prdata_mux = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (psel[i]) begin
        prdata_mux = prdata_mux | prdata[i];
      end
    end
  end

  assign pready_mux = |(psel & pready);
  assign sel_empty  = (psel == '0);

  // Unmapped address ends in its first ACCESS cycle, reads zero
  assign done  = (state == APB_ACCESS) && (pready_mux || sel_empty);
  assign rdata = prdata_mux;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_ff @(posedge hclk30 or negedge hreset_n30) begin
    if (!hreset_n30) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (data_phase) begin
            state  <= APB_SETUP;
            psel   <= slave_sel;
            paddr  <= cmd.addr;
            pwrite <= cmd.write;
          end
        end
        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end
        APB_ACCESS: begin
          // Wait states hold here; always back to IDLE afterwards
          if (done) begin
            state   <= APB_IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end
        default: begin
          state <= APB_IDLE;
        end
      endcase
    end
  end

endmodule : apb_master_fsm

// ==== ahb2apb_bridge.sv ====
/*
 * AHB to APB bridge top level serving four APB slaves on one clock.
 * Connects the AHB slave port, the address decoder and the APB master.
 */

`timescale 1ns/100ps

module ahb2apb_bridge
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  logic        hclk30,
  input  logic        hreset_n30,
  // AHB slave port
  input  logic        hsel,
  input  htrans_e     htrans,
  input  haddr_t      haddr,
  input  logic        hwrite,
  input  hdata_t      hwdata,
  output logic        hready,
  output hdata_t      hrdata,
  // APB master port
  output psel_vec_t   psel,
  output logic        penable,
  output haddr_t      paddr,
  output logic        pwrite,
  output hdata_t      pwdata,
  input  psel_vec_t   pready,
  input  prdata_arr_t prdata
);

  logic      accept;
  logic      data_phase;
  logic      done;
  ahb_cmd_t  cmd;
  hdata_t    rdata;
  psel_vec_t slave_sel;

  ahb_slave_port u_ahb_slave_port (
    .hclk30     (hclk30),
    .hreset_n30 (hreset_n30),
    .hsel       (hsel),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .done       (done),
    .rdata      (rdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .accept     (accept),
    .cmd        (cmd),
    .data_phase (data_phase)
  );

  // Decode registered on the same edge as the command
  apb_slave_decoder u_apb_slave_decoder (
    .hclk30     (hclk30),
    .hreset_n30 (hreset_n30),
    .haddr      (haddr),
    .accept     (accept),
    .slave_sel  (slave_sel)
  );

  apb_master_fsm u_apb_master_fsm (
    .hclk30     (hclk30),
    .hreset_n30 (hreset_n30),
    .data_phase (data_phase),
    .cmd        (cmd),
    .slave_sel  (slave_sel),
    .hwdata     (hwdata),
    .pready     (pready),
    .prdata     (prdata),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .done       (done),
    .rdata      (rdata)
  );

endmodule : ahb2apb_bridge

// ==== ahb2apb_bridge_chk.sv ====
/*
 * APB and AHB protocol assertions, bound into every bridge instance.
 */

`timescale 1ns/100ps

module ahb2apb_bridge_chk
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input logic       hclk30,
  input logic       hreset_n30,
  input logic       hready,
  input psel_vec_t  psel,
  input logic       penable,
  input haddr_t     paddr,
  input apb_state_e fsm_state
);

  // Assertion failures so far
  int unsigned fail_count = 0;

  // At most one slave selected
  a_psel_onehot: assert property (@(posedge hclk30) disable iff (!hreset_n30)
    $onehot0(psel))
    else begin
      $error("psel has more than one bit set");
      fail_count++;
    end

  // penable follows SETUP or is held through wait states
  a_penable_seq: assert property (@(posedge hclk30) disable iff (!hreset_n30)
    penable |-> (($past(fsm_state) == APB_SETUP) || $past(penable)))
    else begin
      $error("penable rose without a preceding SETUP cycle");
      fail_count++;
    end

  a_paddr_stable: assert property (@(posedge hclk30) disable iff (!hreset_n30)
    penable |-> $stable(paddr))
    else begin
      $error("paddr changed during ACCESS");
      fail_count++;
    end

  // AHB side stalled while the APB access runs
  a_hready_low: assert property (@(posedge hclk30) disable iff (!hreset_n30)
    penable |-> !hready)
    else begin
      $error("hready high during an APB access");
      fail_count++;
    end

endmodule : ahb2apb_bridge_chk

bind ahb2apb_bridge ahb2apb_bridge_chk u_chk (
  .hclk30     (hclk30),
  .hreset_n30 (hreset_n30),
  .hready     (hready),
  .psel       (psel),
  .penable    (penable),
  .paddr      (paddr),
  .fsm_state  (u_apb_master_fsm.state)
);

// ==== tb_ahb2apb_bridge.sv ====
/*
 * Testbench for the AHB to APB bridge with four APB slave models.
 * Directed and random transfers are checked against a shadow memory.
 */

`timescale 1ns/100ps

module tb_ahb2apb_bridge
  import ahb_pkg::*;
  import apb_pkg::*;
();

  localparam int          TIMEOUT_CYCLES = 40;
  localparam int          RANDOM_OPS     = 200;
  localparam logic [31:0] LFSR_SEED      = 32'hbeaec586;

  logic        hclk30;
  logic        hreset_n30;
  logic        hsel;
  htrans_e     htrans;
  haddr_t      haddr;
  logic        hwrite;
  hdata_t      hwdata;
  logic        hready;
  hdata_t      hrdata;
  psel_vec_t   psel;
  logic        penable;
  haddr_t      paddr;
  logic        pwrite;
  hdata_t      pwdata;
  psel_vec_t   pready = '0;
  prdata_arr_t prdata = '0;

  hdata_t      slave_mem [NUM_SLAVES][16] = '{default: '0};
  hdata_t      shadow [NUM_SLAVES][16] = '{default: '0};
  int          wait_cnt [NUM_SLAVES] = '{default: 0};
  logic [31:0] lfsr_state = LFSR_SEED;
  logic        zero_wait = 1'b1;

  // Pending checks drained by the compare process
  string       cmp_name_q[$];
  hdata_t      cmp_exp_q[$];
  hdata_t      cmp_act_q[$];

  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_start = 0;
  string       test_name = "none";

  ahb2apb_bridge DUT (
    .hclk30     (hclk30),
    .hreset_n30 (hreset_n30),
    .hsel       (hsel),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pready     (pready),
    .prdata     (prdata)
  );

  initial hclk30 = 1'b0;
  always #20 hclk30 = ~hclk30;

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------
  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Slave index of an address or -1 outside every window
  function automatic int slave_of(input haddr_t addr);
    haddr_t offset;
    offset = addr - SLAVE_BASE;
    if ((offset >> SLAVE_WIN_BITS) >= haddr_t'(NUM_SLAVES)) begin
      return -1;
    end
    return int'(offset >> SLAVE_WIN_BITS);
  endfunction

  // Writes update the shadow; reads return last written data or zero
  function automatic hdata_t ref_access(input haddr_t addr, input logic write,
                                        input hdata_t wdata);
    int s;
    s = slave_of(addr);
    if (s < 0) begin
      return '0;
    end
    if (write) begin
      shadow[s][addr[5:2]] = wdata;
      return '0;
    end
    return shadow[s][addr[5:2]];
  endfunction

  // ----------------------------------------
  // APB slave models
  // ----------------------------------------
  always @(negedge hclk30) begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (psel[i] && !penable) begin
        // SETUP cycle picks 0 to 3 wait states
        wait_cnt[i] = zero_wait ? 0 : int'(random_bits(2));
        pready[i]   = 1'b0;
      end else if (psel[i] && penable && (wait_cnt[i] == 0)) begin
        pready[i] = 1'b1;
        prdata[i] = slave_mem[i][paddr[5:2]];
        if (pwrite) begin
          slave_mem[i][paddr[5:2]] = pwdata;
        end
      end else if (psel[i] && penable) begin
        wait_cnt[i] = wait_cnt[i] - 1;
      end else begin
        pready[i] = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  function automatic void post_check(input hdata_t expected, input hdata_t actual);
    cmp_name_q.push_back(test_name);
    cmp_exp_q.push_back(expected);
    cmp_act_q.push_back(actual);
  endfunction

  always @(negedge hclk30) begin
    while (cmp_act_q.size() > 0) begin
      checks = checks + 1;
      assert (cmp_act_q[0] === cmp_exp_q[0]) else begin
        $display("Fail %s: expected %h, actual %h", cmp_name_q[0], cmp_exp_q[0],
                 cmp_act_q[0]);
        errors = errors + 1;
      end
      void'(cmp_name_q.pop_front());
      void'(cmp_exp_q.pop_front());
      void'(cmp_act_q.pop_front());
    end
  end

  task automatic report_timeout(input string what);
    $display("Timeout in test %s: %s", test_name, what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic end_test();
    int guard;
    guard = 0;
    while (cmp_act_q.size() > 0) begin
      guard = guard + 1;
      if (guard > TIMEOUT_CYCLES) begin
        report_timeout("pending checks were never compared");
      end
      @(negedge hclk30);
    end
    if (errors == test_err_start) begin
      $display("Test %s: passed", test_name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %s: %0d errors", test_name, errors - test_err_start);
    end
  endtask

  // ----------------------------------------
  // AHB driver
  // ----------------------------------------
  // One transfer; also counts hready low cycles and collects psel bits
  task automatic checked_transfer(input haddr_t addr, input logic write,
                                  input hdata_t wdata, input logic check_timing);
    hdata_t    expected;
    psel_vec_t exp_sel;
    psel_vec_t seen_sel;
    int        cycles;
    expected = ref_access(addr, write, wdata);
    exp_sel  = (slave_of(addr) < 0) ? '0 : psel_vec_t'(1 << slave_of(addr));
    @(negedge hclk30);
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = write;
    @(negedge hclk30);
    hsel     = 1'b0;
    htrans   = HTRANS_IDLE;
    hwdata   = wdata;
    cycles   = 0;
    seen_sel = '0;
    while (!hready) begin
      cycles   = cycles + 1;
      seen_sel = seen_sel | psel;
      if (cycles > TIMEOUT_CYCLES) begin
        report_timeout("hready stayed low");
      end
      @(negedge hclk30);
    end
    if (!write) begin
      post_check(expected, hrdata);
    end
    post_check(hdata_t'(exp_sel), hdata_t'(seen_sel));
    if (check_timing) begin
      post_check(32'd3, hdata_t'(cycles));
    end
  endtask

  // Holds a non-transfer request for three cycles
  task automatic idle_request(input logic sel, input htrans_e trans);
    @(negedge hclk30);
    hsel   = sel;
    htrans = trans;
    haddr  = 32'h0000_1004;
    hwrite = 1'b1;
    repeat (3) begin
      @(negedge hclk30);
      post_check('0, hdata_t'(psel));
      post_check(32'd1, hdata_t'(hready));
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    haddr_t addr;
    hdata_t data;
    logic   write;
    hreset_n30 = 1'b0;
    hsel       = 1'b0;
    htrans     = HTRANS_IDLE;
    haddr      = '0;
    hwrite     = 1'b0;
    hwdata     = '0;
    repeat (3) @(posedge hclk30);
    @(negedge hclk30);
    hreset_n30 = 1'b1;

    test_name = "reset_values";
    tests_run = tests_run + 1;
    test_err_start = errors;
    post_check(32'd1, hdata_t'(hready));
    post_check('0, hdata_t'(psel));
    post_check('0, hdata_t'(penable));
    post_check('0, hrdata);
    post_check('0, paddr);
    post_check('0, hdata_t'(pwrite));
    end_test();

    test_name = "zero_wait_slaves";
    tests_run = tests_run + 1;
    test_err_start = errors;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      addr = SLAVE_BASE + (haddr_t'(s) << SLAVE_WIN_BITS) + haddr_t'(4 * s + 8);
      data = 32'h5a00_0000 + hdata_t'(s) * 32'h0001_0101;
      checked_transfer(addr, 1'b1, data, 1'b1);
      checked_transfer(addr, 1'b0, '0, 1'b1);
    end
    end_test();

    test_name = "random_traffic";
    tests_run = tests_run + 1;
    test_err_start = errors;
    zero_wait = 1'b0;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      addr  = SLAVE_BASE + (haddr_t'(random_bits(2)) << SLAVE_WIN_BITS);
      addr  = addr + (haddr_t'(random_bits(4)) << 2);
      write = (random_bits(1) != 0);
      data  = random_bits(32);
      checked_transfer(addr, write, data, 1'b0);
    end
    end_test();

    // Unmapped accesses complete in their first ACCESS cycle
    test_name = "unmapped_address";
    tests_run = tests_run + 1;
    test_err_start = errors;
    checked_transfer(32'h0000_4008, 1'b0, '0, 1'b1);
    checked_transfer(32'h0001_0008, 1'b1, 32'hdead_beef, 1'b1);
    checked_transfer(32'hffff_f004, 1'b1, 32'h1234_5678, 1'b1);
    for (int s = 0; s < NUM_SLAVES; s++) begin
      checked_transfer(SLAVE_BASE + (haddr_t'(s) << SLAVE_WIN_BITS) + 32'h8, 1'b0, '0, 1'b0);
      checked_transfer(SLAVE_BASE + (haddr_t'(s) << SLAVE_WIN_BITS) + 32'h4, 1'b0, '0, 1'b0);
    end
    end_test();

    test_name = "no_transfer_cycles";
    tests_run = tests_run + 1;
    test_err_start = errors;
    idle_request(1'b0, HTRANS_NONSEQ);
    idle_request(1'b1, HTRANS_IDLE);
    idle_request(1'b1, HTRANS_BUSY);
    idle_request(1'b0, HTRANS_SEQ);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    end_test();

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, checks, errors, DUT.u_chk.fail_count);
    if ((errors == 0) && (tests_failed == 0) && (DUT.u_chk.fail_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_ahb2apb_bridge

// ==== ahb2apb_bridge.f ====
ahb_pkg.sv
apb_pkg.sv
ahb_slave_port.sv
apb_slave_decoder.sv
apb_master_fsm.sv
ahb2apb_bridge.sv
ahb2apb_bridge_chk.sv
tb_ahb2apb_bridge.sv

// ==== Makefile ====
TOP := tb_ahb2apb_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f ahb2apb_bridge.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f ahb2apb_bridge.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" sim.log; then \
	  echo "sim: run reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
